/* rtl/csr_pkg.sv */
`default_nettype none

package csr_pkg;

    // --------------------------------------------------
    // Datapath widths
    // --------------------------------------------------
    localparam int ADDR_WIDTH   = 32;
    localparam int DATA_WIDTH   = 32;
    localparam int INDEX_WIDTH  = 24;

    // Consecutive CSR offset words are one 32-bit word apart
    localparam int STRIDE_BYTES = 4;

    // --------------------------------------------------
    // Credits and buffering
    // --------------------------------------------------
    localparam int MEM_CREDITS     = 4;
    localparam int RESP_FIFO_DEPTH = 8;
    localparam int OUT_CREDITS     = 4;

    // Counter widths, sized so the full credit value fits
    localparam int MEM_CREDIT_WIDTH = $clog2(MEM_CREDITS + 1);
    localparam int OUT_CREDIT_WIDTH = $clog2(OUT_CREDITS + 1);
    localparam int RESP_PTR_WIDTH   = $clog2(RESP_FIFO_DEPTH);
    localparam int RESP_CNT_WIDTH   = $clog2(RESP_FIFO_DEPTH + 1);

    // --------------------------------------------------
    // Command opcodes and run states
    // --------------------------------------------------
    typedef enum logic [1:0] {
        CMD_SET_BASE  = 2'd0,
        CMD_SET_START = 2'd1,
        CMD_SET_COUNT = 2'd2,
        CMD_START     = 2'd3
    } csr_cmd_e;

    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_ISSUE = 2'd1,
        ST_DRAIN = 2'd2,
        ST_DONE  = 2'd3
    } csr_state_e;

endpackage : csr_pkg

`default_nettype wire

/* rtl/csr_index_control.sv */
`timescale 1ns/100ps
`default_nettype none

module csr_index_control (
    input  logic                            ap_clk,
    input  logic                            areset_csr_engine,
    input  logic                            cmd_valid,
    input  csr_pkg::csr_cmd_e               cmd_opcode,
    input  logic [csr_pkg::DATA_WIDTH-1:0]  cmd_data,
    input  logic                            issue_done,
    input  logic                            fwd_pulse,
    output logic                            busy,
    output logic                            done,
    output logic                            run_start,
    output logic [csr_pkg::ADDR_WIDTH-1:0]  run_base,
    output logic [csr_pkg::INDEX_WIDTH-1:0] run_first,
    output logic [csr_pkg::INDEX_WIDTH-1:0] run_count
);

    import csr_pkg::*;

    csr_state_e             state;
    csr_state_e             state_next;
    logic [INDEX_WIDTH-1:0] fwd_count;
    logic                   cmd_take;
    logic                   start_take;
    logic                   last_fwd;

    // Commands are only accepted between runs
    assign cmd_take   = cmd_valid && !busy;
    assign start_take = cmd_take && (cmd_opcode == CMD_START);

    // Final output of the run, counted before this pulse lands
    assign last_fwd   = fwd_pulse && (fwd_count == run_count - INDEX_WIDTH'(1));

    // --------------------------------------------------
    // Configuration registers
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (cmd_take) begin
            case (cmd_opcode)
                CMD_SET_BASE:  run_base  <= ADDR_WIDTH'(cmd_data);
                CMD_SET_START: run_first <= cmd_data[INDEX_WIDTH-1:0];
                CMD_SET_COUNT: run_count <= cmd_data[INDEX_WIDTH-1:0];
                default: begin
                end
            endcase
        end
    end

    // --------------------------------------------------
    // Run state machine
    // --------------------------------------------------
    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE, ST_DONE: begin
                // Empty run skips issue and drain altogether
                if (start_take) begin
                    state_next = (run_count == '0) ? ST_DONE : ST_ISSUE;
                end
            end
            ST_ISSUE: begin
                if (issue_done) begin
                    state_next = ST_DRAIN;
                end
            end
            ST_DRAIN: begin
                if (last_fwd) begin
                    state_next = ST_DONE;
                end
            end
            default: state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            state     <= ST_IDLE;
            run_start <= 1'b0;
            fwd_count <= '0;
        end else begin
            state     <= state_next;
            run_start <= start_take && (run_count != '0);
            // Outputs may already leave while requests are still issuing
            if (start_take) begin
                fwd_count <= '0;
            end else if (fwd_pulse) begin
                fwd_count <= fwd_count + INDEX_WIDTH'(1);
            end
        end
    end

    assign busy = (state == ST_ISSUE) || (state == ST_DRAIN);
    assign done = (state == ST_DONE);

endmodule : csr_index_control

`default_nettype wire

/* rtl/csr_request_generator.sv */
`timescale 1ns/100ps
`default_nettype none

module csr_request_generator (
    input  logic                            ap_clk,
    input  logic                            areset_csr_engine,
    input  logic                            run_start,
    input  logic [csr_pkg::ADDR_WIDTH-1:0]  run_base,
    input  logic [csr_pkg::INDEX_WIDTH-1:0] run_first,
    input  logic [csr_pkg::INDEX_WIDTH-1:0] run_count,
    input  logic                            mem_req_credit,
    output logic                            mem_req_valid,
    output logic [csr_pkg::ADDR_WIDTH-1:0]  mem_req_addr,
    output logic [csr_pkg::INDEX_WIDTH-1:0] mem_req_tag,
    output logic                            issue_done
);

    import csr_pkg::*;

    logic [MEM_CREDIT_WIDTH-1:0] credits;
    logic [INDEX_WIDTH-1:0]      index_q;
    logic [INDEX_WIDTH-1:0]      remaining_q;
    logic [INDEX_WIDTH-1:0]      cur_index;
    logic [INDEX_WIDTH-1:0]      cur_remaining;
    logic                        issue;

    // Run start loads the counters and may issue in the same cycle
    assign cur_index     = run_start ? run_first : index_q;
    assign cur_remaining = run_start ? run_count : remaining_q;
    assign issue         = (cur_remaining != '0) && (credits != '0);

    // --------------------------------------------------
    // Request credit counter
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            credits <= MEM_CREDIT_WIDTH'(MEM_CREDITS);
        end else begin
            case ({issue, mem_req_credit})
                2'b10:   credits <= credits - MEM_CREDIT_WIDTH'(1);
                2'b01:   credits <= credits + MEM_CREDIT_WIDTH'(1);
                default: credits <= credits;
            endcase
        end
    end

    // --------------------------------------------------
    // Index walk and request output
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            remaining_q   <= '0;
            mem_req_valid <= 1'b0;
            issue_done    <= 1'b0;
        end else begin
            remaining_q   <= issue ? cur_remaining - INDEX_WIDTH'(1) : cur_remaining;
            mem_req_valid <= issue;
            issue_done    <= issue && (cur_remaining == INDEX_WIDTH'(1));
        end
    end

    always_ff @(posedge ap_clk) begin
        index_q <= issue ? cur_index + INDEX_WIDTH'(1) : cur_index;
        if (issue) begin
            mem_req_addr <= run_base + ADDR_WIDTH'(cur_index) * ADDR_WIDTH'(STRIDE_BYTES);
            mem_req_tag  <= cur_index;
        end
    end

endmodule : csr_request_generator

`default_nettype wire

/* rtl/csr_response_fifo.sv */
`timescale 1ns/100ps
`default_nettype none

module csr_response_fifo (
    input  logic                            ap_clk,
    input  logic                            areset_csr_engine,
    input  logic                            wr_valid,
    input  logic [csr_pkg::DATA_WIDTH-1:0]  wr_data,
    input  logic [csr_pkg::INDEX_WIDTH-1:0] wr_tag,
    input  logic                            pop,
    output logic [csr_pkg::DATA_WIDTH-1:0]  head_data,
    output logic [csr_pkg::INDEX_WIDTH-1:0] head_tag,
    output logic                            empty
);

    import csr_pkg::*;

    logic [DATA_WIDTH-1:0]     data_mem [RESP_FIFO_DEPTH];
    logic [INDEX_WIDTH-1:0]    tag_mem  [RESP_FIFO_DEPTH];
    logic [RESP_PTR_WIDTH-1:0] wr_ptr;
    logic [RESP_PTR_WIDTH-1:0] rd_ptr;
    logic [RESP_CNT_WIDTH-1:0] count;

    // Storage, written every accepted response
    always_ff @(posedge ap_clk) begin
        if (wr_valid) begin
            data_mem[wr_ptr] <= wr_data;
            tag_mem[wr_ptr]  <= wr_tag;
        end
    end

    // Pointers wrap on their own since the depth is a power of two
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_valid) wr_ptr <= wr_ptr + RESP_PTR_WIDTH'(1);
            if (pop)      rd_ptr <= rd_ptr + RESP_PTR_WIDTH'(1);
            case ({wr_valid, pop})
                2'b10:   count <= count + RESP_CNT_WIDTH'(1);
                2'b01:   count <= count - RESP_CNT_WIDTH'(1);
                default: count <= count;
            endcase
        end
    end

    assign head_data = data_mem[rd_ptr];
    assign head_tag  = tag_mem[rd_ptr];
    assign empty     = (count == '0);

endmodule : csr_response_fifo

`default_nettype wire

/* rtl/csr_response_forward.sv */
`timescale 1ns/100ps
`default_nettype none

module csr_response_forward (
    input  logic                            ap_clk,
    input  logic                            areset_csr_engine,
    input  logic                            empty,
    input  logic [csr_pkg::DATA_WIDTH-1:0]  head_data,
    input  logic [csr_pkg::INDEX_WIDTH-1:0] head_tag,
    input  logic                            out_credit,
    output logic                            pop,
    output logic                            out_valid,
    output logic [csr_pkg::DATA_WIDTH-1:0]  out_data,
    output logic [csr_pkg::INDEX_WIDTH-1:0] out_index,
    output logic                            mem_resp_credit,
    output logic                            fwd_pulse
);

    import csr_pkg::*;

    logic [OUT_CREDIT_WIDTH-1:0] credits;

    // Move the head entry whenever the sink can take it
    assign pop = !empty && (credits != '0);

    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            credits   <= OUT_CREDIT_WIDTH'(OUT_CREDITS);
            out_valid <= 1'b0;
        end else begin
            case ({pop, out_credit})
                2'b10:   credits <= credits - OUT_CREDIT_WIDTH'(1);
                2'b01:   credits <= credits + OUT_CREDIT_WIDTH'(1);
                default: credits <= credits;
            endcase
            out_valid <= pop;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (pop) begin
            out_data  <= head_data;
            out_index <= head_tag;
        end
    end

    // A freed FIFO slot goes back to the memory as one response credit
    assign mem_resp_credit = out_valid;
    assign fwd_pulse       = out_valid;

endmodule : csr_response_forward

`default_nettype wire

/* rtl/engine_csr_index.sv */
`timescale 1ns/100ps
`default_nettype none

module engine_csr_index (
    input  logic                            ap_clk,
    input  logic                            areset_csr_engine,
    // Command port
    input  logic                            cmd_valid,
    input  csr_pkg::csr_cmd_e               cmd_opcode,
    input  logic [csr_pkg::DATA_WIDTH-1:0]  cmd_data,
    output logic                            busy,
    output logic                            done,
    // Memory request stream
    output logic                            mem_req_valid,
    output logic [csr_pkg::ADDR_WIDTH-1:0]  mem_req_addr,
    output logic [csr_pkg::INDEX_WIDTH-1:0] mem_req_tag,
    input  logic                            mem_req_credit,
    // Memory response stream
    input  logic                            mem_resp_valid,
    input  logic [csr_pkg::DATA_WIDTH-1:0]  mem_resp_data,
    input  logic [csr_pkg::INDEX_WIDTH-1:0] mem_resp_tag,
    output logic                            mem_resp_credit,
    // Engine output stream
    output logic                            out_valid,
    output logic [csr_pkg::DATA_WIDTH-1:0]  out_data,
    output logic [csr_pkg::INDEX_WIDTH-1:0] out_index,
    input  logic                            out_credit
);

    import csr_pkg::*;

    // --------------------------------------------------
    // Internal wires
    // --------------------------------------------------
    logic                   run_start;
    logic [ADDR_WIDTH-1:0]  run_base;
    logic [INDEX_WIDTH-1:0] run_first;
    logic [INDEX_WIDTH-1:0] run_count;
    logic                   issue_done;
    logic                   fwd_pulse;

    logic                   fifo_pop;
    logic                   fifo_empty;
    logic [DATA_WIDTH-1:0]  fifo_head_data;
    logic [INDEX_WIDTH-1:0] fifo_head_tag;

    // Command decode and run sequencing
    csr_index_control inst_csr_index_control (
        .ap_clk            (ap_clk),
        .areset_csr_engine (areset_csr_engine),
        .cmd_valid         (cmd_valid),
        .cmd_opcode        (cmd_opcode),
        .cmd_data          (cmd_data),
        .issue_done        (issue_done),
        .fwd_pulse         (fwd_pulse),
        .busy              (busy),
        .done              (done),
        .run_start         (run_start),
        .run_base          (run_base),
        .run_first         (run_first),
        .run_count         (run_count)
    );

    // Memory read issue
    csr_request_generator inst_csr_request_generator (
        .ap_clk            (ap_clk),
        .areset_csr_engine (areset_csr_engine),
        .run_start         (run_start),
        .run_base          (run_base),
        .run_first         (run_first),
        .run_count         (run_count),
        .mem_req_credit    (mem_req_credit),
        .mem_req_valid     (mem_req_valid),
        .mem_req_addr      (mem_req_addr),
        .mem_req_tag       (mem_req_tag),
        .issue_done        (issue_done)
    );

    // Response buffering, sized to the memory's response credits
    csr_response_fifo inst_csr_response_fifo (
        .ap_clk            (ap_clk),
        .areset_csr_engine (areset_csr_engine),
        .wr_valid          (mem_resp_valid),
        .wr_data           (mem_resp_data),
        .wr_tag            (mem_resp_tag),
        .pop               (fifo_pop),
        .head_data         (fifo_head_data),
        .head_tag          (fifo_head_tag),
        .empty             (fifo_empty)
    );

    csr_response_forward inst_csr_response_forward (
        .ap_clk            (ap_clk),
        .areset_csr_engine (areset_csr_engine),
        .empty             (fifo_empty),
        .head_data         (fifo_head_data),
        .head_tag          (fifo_head_tag),
        .out_credit        (out_credit),
        .pop               (fifo_pop),
        .out_valid         (out_valid),
        .out_data          (out_data),
        .out_index         (out_index),
        .mem_resp_credit   (mem_resp_credit),
        .fwd_pulse         (fwd_pulse)
    );

endmodule : engine_csr_index

`default_nettype wire

/* dv/engine_csr_index_asserts.sv */
`timescale 1ns/100ps
`default_nettype none

module engine_csr_index_asserts (
    input logic ap_clk,
    input logic areset_csr_engine,
    input logic mem_req_valid,
    input logic mem_req_credit,
    input logic mem_resp_valid,
    input logic mem_resp_credit,
    input logic out_valid,
    input logic out_credit,
    input logic busy,
    input logic done
);

    import csr_pkg::*;

    // Credits as seen from the ports, one counter per stream
    int req_credits;
    int resp_credits;
    int out_credits;

    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            req_credits  <= MEM_CREDITS;
            resp_credits <= RESP_FIFO_DEPTH;
            out_credits  <= OUT_CREDITS;
        end else begin
            req_credits  <= req_credits - int'(mem_req_valid) + int'(mem_req_credit);
            resp_credits <= resp_credits - int'(mem_resp_valid) + int'(mem_resp_credit);
            out_credits  <= out_credits - int'(out_valid) + int'(out_credit);
        end
    end

    req_needs_credit: assert property (@(posedge ap_clk) disable iff (areset_csr_engine)
        mem_req_valid |-> req_credits > 0)
        else $error("memory request issued without a request credit");

    out_needs_credit: assert property (@(posedge ap_clk) disable iff (areset_csr_engine)
        out_valid |-> out_credits > 0)
        else $error("output issued without an output credit");

    // A credit returned in this cycle may be spent at once
    resp_needs_credit: assert property (@(posedge ap_clk) disable iff (areset_csr_engine)
        mem_resp_valid |-> (resp_credits + int'(mem_resp_credit)) > 0)
        else $error("memory response sent without a response credit");

    done_not_busy: assert property (@(posedge ap_clk) disable iff (areset_csr_engine)
        !(done && busy))
        else $error("done and busy high together");

endmodule : engine_csr_index_asserts

bind engine_csr_index engine_csr_index_asserts asserts0 (
    .ap_clk            (ap_clk),
    .areset_csr_engine (areset_csr_engine),
    .mem_req_valid     (mem_req_valid),
    .mem_req_credit    (mem_req_credit),
    .mem_resp_valid    (mem_resp_valid),
    .mem_resp_credit   (mem_resp_credit),
    .out_valid         (out_valid),
    .out_credit        (out_credit),
    .busy              (busy),
    .done              (done)
);

`default_nettype wire

/* dv/tb_engine_csr_index.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_engine_csr_index;

    import csr_pkg::*;

    localparam int WAIT_LIMIT = 4000;

    logic                   ap_clk;
    logic                   areset_csr_engine;
    logic                   cmd_valid;
    csr_cmd_e               cmd_opcode;
    logic [DATA_WIDTH-1:0]  cmd_data;
    logic                   busy;
    logic                   done;
    logic                   mem_req_valid;
    logic [ADDR_WIDTH-1:0]  mem_req_addr;
    logic [INDEX_WIDTH-1:0] mem_req_tag;
    logic                   mem_req_credit;
    logic                   mem_resp_valid;
    logic [DATA_WIDTH-1:0]  mem_resp_data;
    logic [INDEX_WIDTH-1:0] mem_resp_tag;
    logic                   mem_resp_credit;
    logic                   out_valid;
    logic [DATA_WIDTH-1:0]  out_data;
    logic [INDEX_WIDTH-1:0] out_index;
    logic                   out_credit;

    // Test data and memory image
    logic [31:0] tdata [0:255];
    logic [7:0]  tptr;
    logic [31:0] image [0:63];
    logic [31:0] image_base;
    logic [31:0] image_words;

    // Per-run expectations and memory model state
    logic [31:0]            exp_data_q[$];
    logic [31:0]            resp_addr_q[$];
    logic [INDEX_WIDTH-1:0] resp_tag_q[$];
    int                     resp_due_q[$];
    logic [31:0]            run_base;
    logic [31:0]            next_tag;
    logic [31:0]            out_next;
    logic                   done_q;
    int                     req_left;
    int                     req_owed;
    int                     resp_held;
    int                     out_owed;
    int                     cycle;
    int                     last_out;
    int                     errors;
    int unsigned            credit_rate;
    int unsigned            mem_delay;

    engine_csr_index dut0 (.*);

    initial begin
        ap_clk = 1'b0;
        forever #2 ap_clk = ~ap_clk;
    end

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------
    task automatic next_cycle();
        @(posedge ap_clk);
        #1;
    endtask

    task automatic abort_run();
        $display("Some tests failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s, got %0h, expected %0h",
                     $time, what, actual, expected);
            errors++;
            abort_run();
        end
    endtask

    task automatic check_idle();
        check_value(64'(mem_req_valid), 64'd0, "mem_req_valid low while idle");
        check_value(64'(out_valid), 64'd0, "out_valid low while idle");
        check_value(64'(mem_resp_credit), 64'd0, "mem_resp_credit low while idle");
        check_value(64'(busy), 64'd0, "busy low while idle");
        check_value(64'(done), 64'd0, "done low while idle");
    endtask

    function automatic logic [31:0] take_word();
        logic [31:0] word;
        word = tdata[tptr];
        tptr = tptr + 8'd1;
        return word;
    endfunction

    // Words outside the image read back as a pattern of their address
    function automatic logic [31:0] read_image(input logic [31:0] addr);
        logic [31:0] word;
        word = (addr - image_base) >> 2;
        if (addr >= image_base && word < image_words) begin
            return image[word[5:0]];
        end
        return addr ^ 32'h5a5a_c3c3;
    endfunction

    task automatic send_cmd(input csr_cmd_e op, input logic [31:0] data);
        int waited;
        waited = 0;
        next_cycle();
        while (busy) begin
            if (waited == WAIT_LIMIT) begin
                $display("Timeout at %0t: busy never dropped before a command", $time);
                abort_run();
            end
            next_cycle();
            waited++;
        end
        cmd_valid  = 1'b1;
        cmd_opcode = op;
        cmd_data   = data;
        next_cycle();
        cmd_valid  = 1'b0;
    endtask

    task automatic wait_done();
        int waited;
        waited = 0;
        while (!done) begin
            if (waited == WAIT_LIMIT) begin
                $display("Timeout at %0t: done never rose at the end of a run", $time);
                abort_run();
            end
            next_cycle();
            waited++;
        end
    endtask

    task automatic play_run(input int r);
        logic [31:0] start;
        logic [31:0] count;
        // Step away from the memory model's sampling point
        #1;
        run_base = take_word();
        start    = take_word();
        count    = take_word();
        next_tag = start;
        out_next = start;
        req_left = int'(count);
        last_out = -1;
        // Odd runs starve the engine of credits and slow the memory down
        credit_rate = r[0] ? 10 : 70;
        mem_delay   = r[0] ? 12 : 3;
        for (int k = 0; k < int'(count); k++) begin
            exp_data_q.push_back(take_word());
        end
        send_cmd(CMD_SET_BASE, run_base);
        send_cmd(CMD_SET_START, start);
        send_cmd(CMD_SET_COUNT, count);
        send_cmd(CMD_START, 32'd0);
        check_value(64'(busy), 64'(count != 32'd0), "busy once the run starts");
        check_value(64'(done), 64'(count == 32'd0), "done once the run starts");
        wait_done();
        repeat (20) next_cycle();
        check_value(64'(done), 64'd1, "done held after the run");
        check_value(64'(busy), 64'd0, "busy low after the run");
        check_value(64'(req_left), 64'd0, "all requests issued");
        check_value(64'(exp_data_q.size()), 64'd0, "all outputs received");
    endtask

    // --------------------------------------------------
    // Memory model and output sink
    // --------------------------------------------------
    initial begin
        void'($urandom(32'h6a77665f));
        mem_req_credit = 1'b0;
        mem_resp_valid = 1'b0;
        mem_resp_data  = '0;
        mem_resp_tag   = '0;
        out_credit     = 1'b0;
        req_owed       = 0;
        out_owed       = 0;
        resp_held      = RESP_FIFO_DEPTH;
        cycle          = 0;
        last_out       = -1;
        done_q         = 1'b0;
        credit_rate    = 70;
        mem_delay      = 3;
        forever begin
            next_cycle();
            cycle++;
            mem_req_credit = 1'b0;
            mem_resp_valid = 1'b0;
            out_credit     = 1'b0;
            if (mem_req_valid) begin
                check_value(64'(req_left > 0), 64'd1, "request beyond the run count");
                check_value(64'(mem_req_tag), 64'(next_tag), "request tag");
                check_value(64'(mem_req_addr), 64'(run_base + next_tag * 32'(STRIDE_BYTES)),
                            "request address");
                req_owed++;
                check_value(64'(req_owed <= MEM_CREDITS), 64'd1, "requests above credits");
                resp_addr_q.push_back(mem_req_addr);
                resp_tag_q.push_back(mem_req_tag);
                resp_due_q.push_back(cycle + int'($urandom_range(1, mem_delay)));
                next_tag = next_tag + 32'd1;
                req_left--;
            end
            if (mem_resp_credit) resp_held++;
            if (out_valid) begin
                check_value(64'(exp_data_q.size() > 0), 64'd1, "output beyond the run count");
                check_value(64'(out_index), 64'(out_next), "output index");
                check_value(64'(out_data), 64'(exp_data_q.pop_front()), "output data");
                out_owed++;
                check_value(64'(out_owed <= OUT_CREDITS), 64'd1, "outputs above credits");
                out_next = out_next + 32'd1;
                last_out = cycle;
            end
            if (done && !done_q) begin
                check_value(64'(exp_data_q.size()), 64'd0, "all outputs out before done");
                if (last_out >= 0) begin
                    check_value(64'(cycle), 64'(last_out + 1),
                                "done one cycle after last output");
                end
            end
            done_q = done;
            if (req_owed > 0 && $urandom_range(0, 99) < credit_rate) begin
                mem_req_credit = 1'b1;
                req_owed--;
            end
            if (out_owed > 0 && $urandom_range(0, 99) < credit_rate) begin
                out_credit = 1'b1;
                out_owed--;
            end
            if (resp_due_q.size() > 0 && resp_due_q[0] <= cycle && resp_held > 0) begin
                mem_resp_valid = 1'b1;
                mem_resp_data  = read_image(resp_addr_q.pop_front());
                mem_resp_tag   = resp_tag_q.pop_front();
                void'(resp_due_q.pop_front());
                resp_held--;
            end
        end
    end

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial begin
        int runs;
        errors            = 0;
        areset_csr_engine = 1'b1;
        cmd_valid         = 1'b0;
        cmd_opcode        = CMD_SET_BASE;
        cmd_data          = '0;
        $readmemh("dv/csr_testdata.txt", tdata);
        tptr        = 8'd0;
        image_words = take_word();
        image_base  = take_word();
        for (int k = 0; k < int'(image_words); k++) begin
            image[k[5:0]] = take_word();
        end
        repeat (10) begin
            next_cycle();
            check_idle();
        end
        areset_csr_engine = 1'b0;
        repeat (3) begin
            next_cycle();
            check_idle();
        end
        runs = int'(take_word());
        for (int r = 0; r < runs; r++) begin
            play_run(r);
        end
        if (errors == 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            abort_run();
        end
    end

endmodule : tb_engine_csr_index

`default_nettype wire

/* dv/csr_testdata.txt */
// Image: word count and byte address of word 0, then the CSR offset words
00000010 00001000
00000000 00000003 00000007 0000000c 00000010 00000015 0000001b 00000022
0000002a 0000002b 00000031 00000038 00000040 00000049 00000053 0000005e
// Runs: how many, then per run base, start index, count and the expected words
00000004
// Ten offsets from index 2
00001000 00000002 0000000a
00000007 0000000c 00000010 00000015 0000001b 00000022 0000002a 0000002b
00000031 00000038
// New base one stride group up, five offsets from index 1
00001010 00000001 00000005
00000015 0000001b 00000022 0000002a 0000002b
// Empty run
00001000 00000003 00000000
// Whole image, deeper than the response FIFO
00001000 00000000 00000010
00000000 00000003 00000007 0000000c 00000010 00000015 0000001b 00000022
0000002a 0000002b 00000031 00000038 00000040 00000049 00000053 0000005e

/* flist.f */
rtl/csr_pkg.sv
rtl/csr_index_control.sv
rtl/csr_request_generator.sv
rtl/csr_response_fifo.sv
rtl/csr_response_forward.sv
rtl/engine_csr_index.sv
dv/engine_csr_index_asserts.sv
dv/tb_engine_csr_index.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the CSR index engine testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f flist.f --top-module tb_engine_csr_index -o sim_tb

status=0
./obj_dir/sim_tb > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Some tests failed" sim.log; then
    echo "Simulation FAILED"
    exit 1
fi
if [ "$status" -ne 0 ]; then
    echo "Simulation stopped with status $status"
    exit 1
fi
echo "Simulation passed"
